// ==== hyper_config.svh ====
// Assumes a 64 Mbit HyperRAM in fixed single-latency mode, and HYPER_MAX_LEN must be a power of two
`ifndef HYPER_CONFIG_SVH
`define HYPER_CONFIG_SVH

// Word address width, 4M words of 16 bits
`define HYPER_ADDR_W 22

// Initial latency in CK cycles
`define HYPER_LAT_CK 6

// Longest burst in 16-bit words
`define HYPER_MAX_LEN 16

// Configuration register 0, word address in register space
`define HYPER_REG_CFG0 'h800

// Configuration register 0 after a device reset
`define HYPER_CFG0_RESET 16'h8f1f

`endif

// ==== hyper_pkg.sv ====
// Vector widths follow hyper_config.svh and len_t holds a burst length minus one
`default_nettype none

`include "hyper_config.svh"

package hyper_pkg;

  // One byte on DQ
  typedef logic [7:0] byte_t;

  // One data word, sent upper byte first
  typedef logic [15:0] word_t;

  // Bit 1 enables the upper byte
  typedef logic [1:0] strb_t;

  typedef logic [`HYPER_ADDR_W-1:0] addr_t;

  // Burst length minus one
  typedef logic [$clog2(`HYPER_MAX_LEN)-1:0] len_t;

  // Command-address word, shifted out MSB byte first
  typedef logic [47:0] ca_t;

  typedef enum logic [2:0] {
    st_idle,
    st_ca,
    st_latency,
    st_write,
    st_read,
    st_finish
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hyper_ctrl.sv ====
// Fixed latency and linear bursts only, so write and read data move at bus rate without stalls
`default_nettype none
`timescale 1ns/1ps

`include "hyper_config.svh"

module hyper_ctrl import hyper_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_write_i,
  input  logic  req_reg_i,
  input  addr_t req_addr_i,
  input  len_t  req_len_i,
  output logic  wdata_req_o,
  input  word_t wdata_i,
  input  strb_t wstrb_i,
  output logic  rdata_valid_o,
  output word_t rdata_o,
  output logic  done_o,
  output logic  phy_cs_o,
  output byte_t tx_byte_o,
  output logic  tx_oe_o,
  output logic  tx_mask_o,
  output logic  tx_mask_oe_o,
  input  word_t rx_word_i,
  input  logic  rx_valid_i
);

  // Byte counter covers the longest data phase
  localparam int CNT_W = $clog2(2 * `HYPER_MAX_LEN);
  localparam logic [CNT_W-1:0] CA_LAST = CNT_W'(5);
  localparam logic [CNT_W-1:0] LAT_LAST = CNT_W'(2 * `HYPER_LAT_CK - 1);

  ctrl_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             write_q;
  logic             reg_q;
  len_t             len_q;
  ca_t              ca_q;
  ca_t              ca_d;
  logic             wlatch_q;
  word_t            wbuf_q;
  strb_t            wstrb_q;
  logic             data_last;
  logic             rd_win;

  // Command-address word from the request
  always_comb begin
    ca_d = '0;
    ca_d[47] = !req_write_i;
    ca_d[46] = req_reg_i;
    // Linear burst
    ca_d[45] = 1'b1;
    ca_d[44:16] = 29'(req_addr_i[`HYPER_ADDR_W-1:3]);
    ca_d[2:0] = req_addr_i[2:0];
  end

  assign data_last = (cnt_q == {len_q, 1'b1});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= st_idle;
      cnt_q    <= '0;
      wlatch_q <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      wlatch_q <= wdata_req_o;
      done_o   <= 1'b0;
      cnt_q    <= cnt_q + 1'b1;
      unique case (state_q)
        st_idle: begin
          cnt_q <= '0;
          if (req_valid_i) begin
            state_q <= st_ca;
          end
        end
        st_ca: begin
          if (cnt_q == CA_LAST) begin
            cnt_q <= '0;
            // Register writes go straight to data
            state_q <= (write_q && reg_q) ? st_write : st_latency;
          end
        end
        st_latency: begin
          if (cnt_q == LAT_LAST) begin
            cnt_q   <= '0;
            state_q <= write_q ? st_write : st_read;
          end
        end
        st_write, st_read: begin
          if (data_last) begin
            cnt_q   <= '0;
            state_q <= st_finish;
          end
        end
        st_finish: begin
          // Two cycles so the last read word can arrive
          if (cnt_q[0]) begin
            state_q <= st_idle;
            done_o  <= 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      write_q <= req_write_i;
      reg_q   <= req_reg_i;
      len_q   <= req_len_i;
      ca_q    <= ca_d;
    end else if (state_q == st_ca) begin
      ca_q <= {ca_q[39:0], 8'h00};
    end
    // Write word arrives the cycle after its request
    if (wlatch_q) begin
      wbuf_q  <= wdata_i;
      wstrb_q <= wstrb_i;
    end
  end

  // Ask for each write word two cycles before its upper byte goes out
  always_comb begin
    unique case (state_q)
      st_ca:      wdata_req_o = write_q && reg_q && (cnt_q == CA_LAST - 1'b1);
      st_latency: wdata_req_o = write_q && (cnt_q == LAT_LAST - 1'b1);
      st_write:   wdata_req_o = !cnt_q[0] && (cnt_q[CNT_W-1:1] != len_q);
      default:    wdata_req_o = 1'b0;
    endcase
  end

  always_comb begin
    unique case (state_q)
      st_ca:    tx_byte_o = ca_q[47:40];
      st_write: tx_byte_o = cnt_q[0] ? wbuf_q[7:0] : wbuf_q[15:8];
      default:  tx_byte_o = '0;
    endcase
  end

  assign req_ready_o = (state_q == st_idle);
  assign phy_cs_o = (state_q == st_ca) || (state_q == st_latency) ||
                    (state_q == st_write) || (state_q == st_read);

  // DQ stays driven through write latency, so the PHY only pairs read bytes
  assign tx_oe_o = (state_q == st_ca) || (state_q == st_write) ||
                   ((state_q == st_latency) && write_q);

  // RWDS high masks the byte
  assign tx_mask_o = cnt_q[0] ? !wstrb_q[0] : !wstrb_q[1];
  assign tx_mask_oe_o = (state_q == st_write) && !reg_q;

  // Read words trail the bus by three cycles
  // and the last latency filler word lands at read byte one
  assign rd_win = !write_q &&
                  (((state_q == st_read) && (cnt_q > CNT_W'(1))) || (state_q == st_finish));

  assign rdata_valid_o = rx_valid_i && rd_win;
  assign rdata_o = rx_word_i;

endmodule

`default_nettype wire

// ==== hyper_phy.sv ====
// CK changes on the falling clk_i edge and read bytes are sampled on clk_i without RWDS timing
`default_nettype none
`timescale 1ns/1ps

module hyper_phy import hyper_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  phy_cs_i,
  input  byte_t tx_byte_i,
  input  logic  tx_oe_i,
  input  logic  tx_mask_i,
  input  logic  tx_mask_oe_i,
  output word_t rx_word_o,
  output logic  rx_valid_o,
  output logic  hyper_cs_no,
  output logic  hyper_ck_o,
  output logic  hyper_rwds_o,
  input  logic  hyper_rwds_i,
  output logic  hyper_rwds_oe_o,
  output byte_t hyper_dq_o,
  input  byte_t hyper_dq_i,
  output logic  hyper_dq_oe_o,
  output logic  hyper_reset_no
);

  byte_t rx_hi_q;
  logic  rx_hi_vld_q;
  logic  rx_take;
  logic  rx_upper;

  // Pad control
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hyper_cs_no     <= 1'b1;
      hyper_dq_oe_o   <= 1'b0;
      hyper_rwds_oe_o <= 1'b0;
      hyper_reset_no  <= 1'b0;
    end else begin
      hyper_cs_no     <= !phy_cs_i;
      hyper_dq_oe_o   <= tx_oe_i;
      hyper_rwds_oe_o <= tx_mask_oe_i;
      hyper_reset_no  <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    hyper_dq_o   <= tx_byte_i;
    hyper_rwds_o <= tx_mask_i;
  end

  // Each CK edge falls mid-byte, so the device sees stable DQ
  always_ff @(negedge clk_i) begin
    if (rst_i || hyper_cs_no) begin
      hyper_ck_o <= 1'b0;
    end else begin
      hyper_ck_o <= !hyper_ck_o;
    end
  end

  // Capture while selected and released
  assign rx_take = !hyper_cs_no && !hyper_dq_oe_o;

  // RWDS high marks an upper byte, otherwise pairing follows the byte count
  assign rx_upper = hyper_rwds_i || !rx_hi_vld_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_hi_vld_q <= 1'b0;
      rx_valid_o  <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (!rx_take) begin
        rx_hi_vld_q <= 1'b0;
      end else if (rx_upper) begin
        rx_hi_vld_q <= 1'b1;
      end else begin
        rx_hi_vld_q <= 1'b0;
        rx_valid_o  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_take) begin
      if (rx_upper) begin
        rx_hi_q <= hyper_dq_i;
      end else begin
        rx_word_o <= {rx_hi_q, hyper_dq_i};
      end
    end
  end

endmodule

`default_nettype wire

// ==== hyperbus.sv ====
// One HyperRAM on one chip select with a single request in flight at a time
`default_nettype none
`timescale 1ns/1ps

module hyperbus import hyper_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_write_i,
  input  logic  req_reg_i,
  input  addr_t req_addr_i,
  input  len_t  req_len_i,
  output logic  wdata_req_o,
  input  word_t wdata_i,
  input  strb_t wstrb_i,
  output logic  rdata_valid_o,
  output word_t rdata_o,
  output logic  done_o,
  output logic  hyper_cs_no,
  output logic  hyper_ck_o,
  output logic  hyper_rwds_o,
  input  logic  hyper_rwds_i,
  output logic  hyper_rwds_oe_o,
  output byte_t hyper_dq_o,
  input  byte_t hyper_dq_i,
  output logic  hyper_dq_oe_o,
  output logic  hyper_reset_no
);

  logic  phy_cs;
  byte_t tx_byte;
  logic  tx_oe;
  logic  tx_mask;
  logic  tx_mask_oe;
  word_t rx_word;
  logic  rx_valid;

  hyper_ctrl hyper_ctrl_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_write_i   (req_write_i),
    .req_reg_i     (req_reg_i),
    .req_addr_i    (req_addr_i),
    .req_len_i     (req_len_i),
    .wdata_req_o   (wdata_req_o),
    .wdata_i       (wdata_i),
    .wstrb_i       (wstrb_i),
    .rdata_valid_o (rdata_valid_o),
    .rdata_o       (rdata_o),
    .done_o        (done_o),
    .phy_cs_o      (phy_cs),
    .tx_byte_o     (tx_byte),
    .tx_oe_o       (tx_oe),
    .tx_mask_o     (tx_mask),
    .tx_mask_oe_o  (tx_mask_oe),
    .rx_word_i     (rx_word),
    .rx_valid_i    (rx_valid)
  );

  hyper_phy hyper_phy_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .phy_cs_i        (phy_cs),
    .tx_byte_i       (tx_byte),
    .tx_oe_i         (tx_oe),
    .tx_mask_i       (tx_mask),
    .tx_mask_oe_i    (tx_mask_oe),
    .rx_word_o       (rx_word),
    .rx_valid_o      (rx_valid),
    .hyper_cs_no     (hyper_cs_no),
    .hyper_ck_o      (hyper_ck_o),
    .hyper_rwds_o    (hyper_rwds_o),
    .hyper_rwds_i    (hyper_rwds_i),
    .hyper_rwds_oe_o (hyper_rwds_oe_o),
    .hyper_dq_o      (hyper_dq_o),
    .hyper_dq_i      (hyper_dq_i),
    .hyper_dq_oe_o   (hyper_dq_oe_o),
    .hyper_reset_no  (hyper_reset_no)
  );

endmodule

`default_nettype wire

// ==== hyperram_model.sv ====
// Simulation-only HyperRAM with 1024 words mirrored over the address space, fixed latency, RWDS held low
`default_nettype none
`timescale 1ns/1ps

`include "hyper_config.svh"

module hyperram_model import hyper_pkg::*; (
  input  logic  hyper_cs_ni,
  input  logic  hyper_ck_i,
  input  logic  hyper_reset_ni,
  input  byte_t hyper_dq_i,
  input  logic  hyper_rwds_i,
  output byte_t hyper_dq_o,
  output logic  hyper_rwds_o
);

  // First data byte after command-address and latency
  localparam int DATA_START = 6 + 2 * `HYPER_LAT_CK;

  word_t mem [0:1023];
  // Powers up at its reset value as well
  word_t cfg0 = `HYPER_CFG0_RESET;
  ca_t   ca;
  int    edge_cnt;
  int    m;
  logic  rd;
  logic  rg;
  addr_t base;
  addr_t wa;
  word_t rword;
  byte_t hi_byte;

  assign hyper_rwds_o = 1'b0;

  // Both CK edges carry a byte, counted from chip select low
  always @(posedge hyper_ck_i or negedge hyper_ck_i or posedge hyper_cs_ni
           or negedge hyper_reset_ni) begin
    if (!hyper_reset_ni) begin
      cfg0 = `HYPER_CFG0_RESET;
      edge_cnt = 0;
      hyper_dq_o <= '0;
    end else if (hyper_cs_ni) begin
      edge_cnt = 0;
    end else begin
      if (edge_cnt < 6) begin
        ca = {ca[39:0], hyper_dq_i};
        rd = ca[47];
        rg = ca[46];
        base = addr_t'({ca[44:16], ca[2:0]});
      end else if (rd) begin
        m = edge_cnt - DATA_START;
        if (m >= 0) begin
          wa = base + addr_t'(m / 2);
          if (rg) begin
            rword = (wa == addr_t'(`HYPER_REG_CFG0)) ? cfg0 : '0;
          end else begin
            rword = mem[wa[9:0]];
          end
          hyper_dq_o <= m[0] ? rword[7:0] : rword[15:8];
        end
      end else begin
        // Register writes have no latency and no byte mask
        m = edge_cnt - (rg ? 6 : DATA_START);
        if (m >= 0) begin
          wa = base + addr_t'(m / 2);
          if (rg) begin
            if (!m[0]) begin
              hi_byte = hyper_dq_i;
            end else if (wa == addr_t'(`HYPER_REG_CFG0)) begin
              cfg0 = {hi_byte, hyper_dq_i};
            end
          end else if (!hyper_rwds_i) begin
            if (!m[0]) begin
              mem[wa[9:0]][15:8] = hyper_dq_i;
            end else begin
              mem[wa[9:0]][7:0] = hyper_dq_i;
            end
          end
        end
      end
      edge_cnt = edge_cnt + 1;
    end
  end

endmodule

`default_nettype wire

// ==== hyperbus_tb.sv ====
// Directed testbench, addresses stay below 1024 because the memory model mirrors above that
`default_nettype none
`timescale 1ns/1ps

`include "hyper_config.svh"

module hyperbus_tb import hyper_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int WATCHDOG_CYCLES = 16 + 6 * 400;

  logic clk_i;
  logic rst_i;
  logic req_valid_i, req_ready_o, req_write_i, req_reg_i;
  addr_t req_addr_i;
  len_t req_len_i;
  logic wdata_req_o, rdata_valid_o, done_o;
  word_t wdata_i, rdata_o;
  strb_t wstrb_i;
  logic cs_n, ck, rwds_to_dev, rwds_to_ctrl, rwds_oe, dq_oe, reset_n;
  byte_t dq_to_dev, dq_to_ctrl;

  word_t wdata_q[$];
  strb_t wstrb_q[$];
  word_t rd_q[$];
  word_t shadow [0:1023];
  int done_cnt = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  hyperbus hyperbus_inst (
    .clk_i(clk_i), .rst_i(rst_i), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .req_write_i(req_write_i), .req_reg_i(req_reg_i), .req_addr_i(req_addr_i),
    .req_len_i(req_len_i), .wdata_req_o(wdata_req_o), .wdata_i(wdata_i), .wstrb_i(wstrb_i),
    .rdata_valid_o(rdata_valid_o), .rdata_o(rdata_o), .done_o(done_o),
    .hyper_cs_no(cs_n), .hyper_ck_o(ck), .hyper_rwds_o(rwds_to_dev),
    .hyper_rwds_i(rwds_to_ctrl), .hyper_rwds_oe_o(rwds_oe), .hyper_dq_o(dq_to_dev),
    .hyper_dq_i(dq_to_ctrl), .hyper_dq_oe_o(dq_oe), .hyper_reset_no(reset_n)
  );

  hyperram_model model_inst (
    .hyper_cs_ni(cs_n), .hyper_ck_i(ck), .hyper_reset_ni(reset_n), .hyper_dq_i(dq_to_dev),
    .hyper_rwds_i(rwds_to_dev), .hyper_dq_o(dq_to_ctrl), .hyper_rwds_o(rwds_to_ctrl)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (rdata_valid_o) rd_q.push_back(rdata_o);
    if (done_o) done_cnt++;
  end

  // Write word is due in the cycle after its request
  always @(negedge clk_i) begin
    if (wdata_req_o) begin
      @(posedge clk_i);
      #10;
      if (wdata_q.size() > 0) begin
        wdata_i = wdata_q.pop_front();
        wstrb_i = wstrb_q.pop_front();
      end else begin
        $display("controller asked for a write word that the test did not supply");
        errors++;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic issue_request(input logic wr, input logic rg, input addr_t a, input int n);
    logic accepted;
    req_write_i = wr;
    req_reg_i = rg;
    req_addr_i = a;
    req_len_i = len_t'(n - 1);
    req_valid_i = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      @(posedge clk_i);
      #10;
    end
    req_valid_i = 1'b0;
    do @(negedge clk_i); while (!done_o);
    @(posedge clk_i);
    #10;
  endtask

  // Caller fills wdata_q and wstrb_q first
  task automatic mem_write(input addr_t a, input int n);
    issue_request(1'b1, 1'b0, a, n);
    check_count(wdata_q.size(), 0, "unused write words");
  endtask

  task automatic mem_read(input addr_t a, input int n);
    rd_q.delete();
    issue_request(1'b0, 1'b0, a, n);
    check_count(rd_q.size(), n, "read word count");
  endtask

  task automatic reg_access(input logic wr, input word_t wv, output word_t rv);
    rd_q.delete();
    if (wr) begin
      wdata_q.push_back(wv);
      wstrb_q.push_back(2'b11);
    end
    issue_request(wr, 1'b1, addr_t'(`HYPER_REG_CFG0), 1);
    check_count(rd_q.size(), wr ? 0 : 1, "register read word count");
    rv = (rd_q.size() > 0) ? rd_q[0] : '0;
  endtask

  task automatic close_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  // Byte merge by strobe, bit 1 for the upper byte
  function automatic word_t merge(input word_t old, input word_t nw, input strb_t s);
    return {s[1] ? nw[15:8] : old[15:8], s[0] ? nw[7:0] : old[7:0]};
  endfunction

  initial begin
    int e;
    int n;
    int d0;
    addr_t a;
    word_t v;
    void'($urandom(32'h829c));
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_reg_i = 1'b0;
    req_addr_i = '0;
    req_len_i = '0;
    wdata_i = '0;
    wstrb_i = '0;
    repeat (16) @(posedge clk_i);
    #10;
    e = errors;
    check_count(int'(reset_n), 0, "hyper_reset_no in reset");
    rst_i = 1'b0;

    @(negedge clk_i);
    check_count(int'(req_ready_o), 1, "req_ready_o");
    check_count(int'(cs_n), 1, "hyper_cs_no");
    check_count(int'(ck), 0, "hyper_ck_o");
    check_count(int'(dq_oe) + int'(rwds_oe), 0, "output enables");
    check_count(int'(done_o) + int'(rdata_valid_o) + int'(wdata_req_o), 0, "user strobes");
    @(posedge clk_i);
    #10;
    check_count(int'(reset_n), 1, "hyper_reset_no after reset");
    close_test("after reset", e);

    e = errors;
    reg_access(1'b0, '0, v);
    check_word(v, `HYPER_CFG0_RESET, "cfg0 reset value");
    close_test("register reset value", e);

    e = errors;
    d0 = done_cnt;
    reg_access(1'b1, 16'h8f17, v);
    reg_access(1'b0, '0, v);
    check_word(v, 16'h8f17, "cfg0 after write");
    repeat (4) @(posedge clk_i);
    #10;
    check_count(done_cnt - d0, 2, "done pulses");
    close_test("register write and read", e);

    e = errors;
    a = addr_t'('h040);
    for (int i = 0; i < 16; i++) begin
      wdata_q.push_back(word_t'(a + addr_t'(i)));
      wstrb_q.push_back(2'b11);
    end
    mem_write(a, 16);
    mem_read(a, 16);
    for (int i = 0; i < rd_q.size() && i < 16; i++) begin
      check_word(rd_q[i], word_t'(a + addr_t'(i)), "burst read");
    end
    close_test("16-word burst", e);

    e = errors;
    a = addr_t'('h080);
    for (int i = 0; i < 16; i++) begin
      wdata_q.push_back(16'hffff);
      wstrb_q.push_back(2'b11);
    end
    mem_write(a, 16);
    for (int i = 0; i < 16; i++) begin
      wdata_q.push_back(16'h3456);
      wstrb_q.push_back(strb_t'(i % 4));
    end
    mem_write(a, 16);
    mem_read(a, 16);
    for (int i = 0; i < rd_q.size() && i < 16; i++) begin
      check_word(rd_q[i], merge(16'hffff, 16'h3456, strb_t'(i % 4)), "strobed read");
    end
    close_test("strobed write", e);

    e = errors;
    for (int t = 0; t < 20; t++) begin
      a = addr_t'($urandom % 1000);
      n = 1 + ($urandom % 4);
      for (int i = 0; i < n; i++) begin
        v = word_t'($urandom);
        shadow[a + i] = v;
        wdata_q.push_back(v);
        wstrb_q.push_back(2'b11);
      end
      mem_write(a, n);
      mem_read(a, n);
      for (int i = 0; i < rd_q.size() && i < n; i++) begin
        check_word(rd_q[i], shadow[a + i], "random read");
      end
    end
    close_test("random bursts", e);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
hyper_pkg.sv
hyper_ctrl.sv
hyper_phy.sv
hyperbus.sv
hyperram_model.sv
hyperbus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status is 1 unless the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module hyperbus_tb -f build.f -o hyperbus_sim \
  && ./obj_dir/hyperbus_sim | tee /dev/stderr | grep -qx "Simulation finished: PASS" \
  && exit 0 \
  || { echo "simulation did not pass"; exit 1; }
